// File: hw/buf_cfg_pkg.sv
// default sizes only; every module still takes its widths as parameters from the top level
package buf_cfg_pkg;

    // **********************************************************
    // word and address sizes
    // **********************************************************

    // payload width of one stream word
    localparam int data_width_def = 8;

    // fifo memory holds 2**addr_width_def words
    // total buffering adds the fwft stage and the sender register
    localparam int addr_width_def = 4;

endpackage

// File: hw/link_pkg.sv
// state encoding for both four-phase controllers; two bits, each side uses only the phases it runs
package link_pkg;

    // **********************************************************
    // four-phase handshake phases
    // **********************************************************

    // idle           no transfer in progress
    // wait_ack_rise  sender holds req high, waits for ack
    // wait_req_fall  receiver holds ack high, waits for req low
    // wait_ack_fall  sender has dropped req, waits for ack low
    typedef enum logic [1:0] {
        idle          = 2'b00,
        wait_ack_rise = 2'b01,
        wait_req_fall = 2'b10,
        wait_ack_fall = 2'b11
    } link_state_t;

endpackage

// File: hw/fifo_mem.sv
// circular buffer of 2**ADDR_WIDTH words; push on full and pop on empty are dropped, read data lags pop by one cycle
`timescale 1ns/100ps

module fifo_mem #(
    parameter int DATA_WIDTH = 8,
    parameter int ADDR_WIDTH = 4
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  push,
    input  logic                  pop,
    input  logic [DATA_WIDTH-1:0] data_in,
    output logic [DATA_WIDTH-1:0] data_out,
    output logic                  empty,
    output logic                  full,
    output logic [ADDR_WIDTH:0]   fifo_count
);

    // **********************************************************
    // storage and pointers
    // **********************************************************

    localparam logic [ADDR_WIDTH:0] depth = 1 << ADDR_WIDTH;

    logic [DATA_WIDTH-1:0] mem [0:depth-1];
    logic [ADDR_WIDTH-1:0] wr_ptr;
    logic [ADDR_WIDTH-1:0] rd_ptr;
    logic [ADDR_WIDTH:0]   count;
    logic                  do_push;
    logic                  do_pop;

    // strobes that actually take effect
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // flags straight from the word count
    assign empty      = (count == '0);
    assign full       = (count == depth);
    assign fifo_count = count;

    // **********************************************************
    // pointer and count update
    // **********************************************************

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // pointers wrap on their own at 2**ADDR_WIDTH
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // push and pop together leave the count alone
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // **********************************************************
    // memory write and registered read
    // **********************************************************

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= data_in;
        end
    end

    // head word lands in data_out at the popping edge
    always_ff @(posedge clk) begin
        if (do_pop) begin
            data_out <= mem[rd_ptr];
        end
    end

endmodule

// File: hw/fifo_fwft.sv
// fall-through fifo; data_out is valid whenever empty is low, full and fifo_count cover the memory only
`timescale 1ns/100ps

module fifo_fwft #(
    parameter int DATA_WIDTH = 8,
    parameter int ADDR_WIDTH = 4
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  push,
    input  logic                  pop,
    input  logic [DATA_WIDTH-1:0] data_in,
    output logic [DATA_WIDTH-1:0] data_out,
    output logic                  empty,
    output logic                  full,
    output logic [ADDR_WIDTH:0]   fifo_count
);

    logic fifo_pop;
    logic fifo_empty;
    logic dout_valid;

    // **********************************************************
    // prefetch control
    // **********************************************************

    // refill output stage when it is free or being consumed
    assign fifo_pop = !fifo_empty && (!dout_valid || pop);
    assign empty    = !dout_valid;

    // refill wins over a pop in the same cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            dout_valid <= 1'b0;
        end else if (fifo_pop) begin
            dout_valid <= 1'b1;
        end else if (pop) begin
            dout_valid <= 1'b0;
        end
    end

    // **********************************************************
    // backing memory
    // **********************************************************

    // registered read data doubles as the output stage
    fifo_mem #(
        .DATA_WIDTH (DATA_WIDTH),
        .ADDR_WIDTH (ADDR_WIDTH)
    ) fifo_buffer (
        .clk        (clk),
        .reset      (reset),
        .push       (push),
        .pop        (fifo_pop),
        .data_in    (data_in),
        .data_out   (data_out),
        .empty      (fifo_empty),
        .full       (full),
        .fifo_count (fifo_count)
    );

endmodule

// File: hw/link_rx.sv
// four-phase receiver synchronous to clk; in_data must hold while in_req is high, requests wait while full
`timescale 1ns/100ps

module link_rx
    import link_pkg::*;
#(
    parameter int DATA_WIDTH = 8
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  in_req,
    input  logic [DATA_WIDTH-1:0] in_data,
    input  logic                  full,
    output logic                  in_ack,
    output logic                  push,
    output logic [DATA_WIDTH-1:0] wr_data
);

    link_state_t state;

    // **********************************************************
    // handshake outputs
    // **********************************************************

    // one push per request, only from idle
    assign push    = (state == idle) && in_req && !full;
    // ack is high for the whole wait on req low
    assign in_ack  = (state == wait_req_fall);
    // data only meaningful while req is up
    assign wr_data = in_data & {DATA_WIDTH{in_req}};

    // **********************************************************
    // state machine
    // **********************************************************

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    // word goes in now, ack follows at this edge
                    if (push) begin
                        state <= wait_req_fall;
                    end
                end
                wait_req_fall: begin
                    // drop ack once source releases req
                    if (!in_req) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

endmodule

// File: hw/link_tx.sv
// four-phase sender synchronous to clk; one word in flight, next pop only after out_ack has fallen
`timescale 1ns/100ps

module link_tx
    import link_pkg::*;
#(
    parameter int DATA_WIDTH = 8
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  empty,
    input  logic [DATA_WIDTH-1:0] rd_data,
    input  logic                  out_ack,
    output logic                  out_req,
    output logic [DATA_WIDTH-1:0] out_data,
    output logic                  pop
);

    link_state_t state;

    // **********************************************************
    // handshake outputs
    // **********************************************************

    // take head word whenever idle and one is there
    assign pop     = (state == idle) && !empty;
    // req stays high until ack is seen
    assign out_req = (state == wait_ack_rise);

    // holding register, stable for the whole handshake
    always_ff @(posedge clk) begin
        if (pop) begin
            out_data <= rd_data;
        end
    end

    // **********************************************************
    // state machine
    // **********************************************************

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (pop) begin
                        state <= wait_ack_rise;
                    end
                end
                wait_ack_rise: begin
                    // sink has the word, release req
                    if (out_ack) begin
                        state <= wait_ack_fall;
                    end
                end
                wait_ack_fall: begin
                    // link back at rest
                    if (!out_ack) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

endmodule

// File: hw/stream_buffer.sv
// holds 2**ADDR_WIDTH+2 words in total; level and full report the memory only, not the two stage registers
`timescale 1ns/100ps

module stream_buffer
    import buf_cfg_pkg::*;
#(
    parameter int DATA_WIDTH = data_width_def,
    parameter int ADDR_WIDTH = addr_width_def
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  in_req,
    input  logic [DATA_WIDTH-1:0] in_data,
    input  logic                  out_ack,
    output logic                  in_ack,
    output logic                  out_req,
    output logic [DATA_WIDTH-1:0] out_data,
    output logic [ADDR_WIDTH:0]   level,
    output logic                  full
);

    // **********************************************************
    // internal strobes and data
    // **********************************************************

    logic                  push;
    logic                  pop;
    logic                  empty;
    logic [DATA_WIDTH-1:0] wr_data;
    logic [DATA_WIDTH-1:0] rd_data;

    // inlet side
    link_rx #(
        .DATA_WIDTH (DATA_WIDTH)
    ) link_rx_i (
        .clk     (clk),
        .reset   (reset),
        .in_req  (in_req),
        .in_data (in_data),
        .full    (full),
        .in_ack  (in_ack),
        .push    (push),
        .wr_data (wr_data)
    );

    // buffer with head word kept ready
    fifo_fwft #(
        .DATA_WIDTH (DATA_WIDTH),
        .ADDR_WIDTH (ADDR_WIDTH)
    ) fifo_fwft_i (
        .clk        (clk),
        .reset      (reset),
        .push       (push),
        .pop        (pop),
        .data_in    (wr_data),
        .data_out   (rd_data),
        .empty      (empty),
        .full       (full),
        .fifo_count (level)
    );

    // outlet side
    link_tx #(
        .DATA_WIDTH (DATA_WIDTH)
    ) link_tx_i (
        .clk      (clk),
        .reset    (reset),
        .empty    (empty),
        .rd_data  (rd_data),
        .out_ack  (out_ack),
        .out_req  (out_req),
        .out_data (out_data),
        .pop      (pop)
    );

endmodule

// File: testbench/tb_stream_buffer.sv
// directed tests for stream_buffer at package default sizes; source and sink are clocked four-phase models
`timescale 1ns/100ps

module tb_stream_buffer
    import buf_cfg_pkg::*;
;

    localparam int data_width     = data_width_def;
    localparam int addr_width     = addr_width_def;
    localparam int depth          = 1 << addr_width;
    localparam int num_tests      = 5;
    localparam int words_per_test = 40;
    // long enough for every test even with slow handshakes
    localparam int watchdog_ns    = num_tests * words_per_test * 20 * 40;

    logic                  clk = 1'b0;
    logic                  reset;
    logic                  in_req;
    logic [data_width-1:0] in_data;
    logic                  out_ack;
    logic                  in_ack;
    logic                  out_req;
    logic [data_width-1:0] out_data;
    logic [addr_width:0]   level;
    logic                  full;

    // words the source completed, in order
    logic [data_width-1:0] expected_q[$];
    int seed = 65;
    int data_errors = 0;
    int level_errors = 0;
    int flag_errors = 0;
    int other_errors = 0;

    stream_buffer #(
        .DATA_WIDTH (data_width),
        .ADDR_WIDTH (addr_width)
    ) dut_i (
        .clk      (clk),
        .reset    (reset),
        .in_req   (in_req),
        .in_data  (in_data),
        .out_ack  (out_ack),
        .in_ack   (in_ack),
        .out_req  (out_req),
        .out_data (out_data),
        .level    (level),
        .full     (full)
    );

    // 40 ns period
    always #20 clk = ~clk;

    // ************************************************************
    // compare tasks and failure notes
    // ************************************************************

    task automatic check_data(input string name, input logic [data_width-1:0] got,
                              input logic [data_width-1:0] exp);
        if (got !== exp) begin
            $display("[ERROR] t=%0t %s got %h expected %h", $time, name, got, exp);
            data_errors++;
        end
    endtask

    task automatic check_level(input string name, input logic [addr_width:0] got,
                               input logic [addr_width:0] exp);
        if (got !== exp) begin
            $display("[ERROR] t=%0t %s got %0d expected %0d", $time, name, got, exp);
            level_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] t=%0t %s got %b expected %b", $time, name, got, exp);
            flag_errors++;
        end
    endtask

    task automatic note_failure(input string msg);
        $display("t=%0t %s", $time, msg);
        other_errors++;
    endtask

    // ************************************************************
    // link models, entered and left on a falling edge
    // ************************************************************

    // source side; an unanswered request is left high
    task automatic send_word(input logic [data_width-1:0] word, input int limit,
                             output bit accepted);
        int waited;
        waited   = 0;
        accepted = 1'b0;
        in_data  = word;
        in_req   = 1'b1;
        while (!accepted && waited < limit) begin
            @(negedge clk);
            if (in_ack) begin
                accepted = 1'b1;
            end else begin
                waited++;
            end
        end
        if (accepted) begin
            expected_q.push_back(word);
            in_req = 1'b0;
            waited = 0;
            while (in_ack && waited < limit) begin
                @(negedge clk);
                waited++;
            end
            if (in_ack) begin
                note_failure("inlet ack stayed high after the request was dropped");
            end
        end
    endtask

    // sink side; checks each word against the oldest completed inlet word
    task automatic receive_word(input int delay, input int limit);
        int waited;
        logic [data_width-1:0] expected;
        waited = 0;
        while (!out_req && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        if (!out_req) begin
            note_failure("no outlet request arrived in time");
            return;
        end
        if (expected_q.size() == 0) begin
            note_failure("outlet delivered a word that the source never sent");
        end else begin
            expected = expected_q.pop_front();
            check_data("out_data", out_data, expected);
        end
        repeat (delay) @(negedge clk);
        out_ack = 1'b1;
        waited  = 0;
        while (out_req && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        if (out_req) begin
            note_failure("outlet request stayed high after ack was raised");
        end
        out_ack = 1'b0;
    endtask

    // ************************************************************
    // directed tests
    // ************************************************************

    task automatic test_reset_state();
        check_flag("in_ack", in_ack, 1'b0);
        check_flag("out_req", out_req, 1'b0);
        check_flag("full", full, 1'b0);
        check_level("level", level, '0);
    endtask

    task automatic test_single_word();
        bit acc;
        fork
            send_word(8'h5a, 20, acc);
            receive_word(0, 20);
        join
        if (!acc) begin
            note_failure("single word was not accepted by the empty buffer");
        end
        // no second outlet handshake may follow
        repeat (10) begin
            @(negedge clk);
            check_flag("out_req", out_req, 1'b0);
        end
        check_level("level", level, '0);
    endtask

    task automatic test_random_stream();
        logic [data_width-1:0] words [words_per_test];
        int src_delay [words_per_test];
        int snk_delay [words_per_test];
        int rnd;
        bit acc;
        // all random values drawn up front, one process only
        for (int i = 0; i < words_per_test; i++) begin
            rnd          = $random(seed);
            words[i]     = rnd[data_width-1:0];
            src_delay[i] = {$random(seed)} % 4;
            snk_delay[i] = {$random(seed)} % 4;
        end
        fork
            for (int i = 0; i < words_per_test; i++) begin
                repeat (src_delay[i]) @(negedge clk);
                send_word(words[i], 40, acc);
                if (!acc) begin
                    note_failure("stream word was refused by the inlet");
                end
            end
            for (int i = 0; i < words_per_test; i++) begin
                receive_word(snk_delay[i], 80);
            end
        join
        if (expected_q.size() != 0) begin
            note_failure("stream words were lost inside the buffer");
        end
        check_level("level", level, '0);
        check_flag("full", full, 1'b0);
    endtask

    // sink held off; memory plus fwft stage plus sender register
    task automatic test_fill_stalled(output logic [data_width-1:0] waiting);
        int rnd;
        bit acc;
        out_ack = 1'b0;
        for (int i = 0; i < depth + 2; i++) begin
            rnd = $random(seed);
            send_word(rnd[data_width-1:0], 20, acc);
            if (!acc) begin
                note_failure("word refused before the buffer reached its capacity");
            end
        end
        check_flag("full", full, 1'b1);
        check_level("level", level, depth[addr_width:0]);
        rnd     = $random(seed);
        waiting = rnd[data_width-1:0];
        send_word(waiting, 50, acc);
        if (acc) begin
            note_failure("inlet accepted a word while the buffer was full");
        end
        // sender still holds its word for the stalled sink
        check_flag("out_req", out_req, 1'b1);
    endtask

    task automatic test_drain(input logic [data_width-1:0] waiting);
        bit acc;
        fork
            send_word(waiting, 100, acc);
            for (int i = 0; i < depth + 3; i++) begin
                receive_word({$random(seed)} % 3, 100);
            end
        join
        if (!acc) begin
            note_failure("waiting inlet word was never accepted after the sink resumed");
        end
        if (expected_q.size() != 0) begin
            note_failure("held words did not all drain");
        end
        // nothing may follow the last drained word
        repeat (10) begin
            @(negedge clk);
            check_flag("out_req", out_req, 1'b0);
        end
        check_level("level", level, '0);
        check_flag("full", full, 1'b0);
    endtask

    // ************************************************************
    // sequence, watchdog and summary
    // ************************************************************

    initial begin
        logic [data_width-1:0] waiting;
        reset   = 1'b1;
        in_req  = 1'b0;
        in_data = '0;
        out_ack = 1'b0;
        repeat (8) @(negedge clk);
        reset = 1'b0;
        test_reset_state();
        test_single_word();
        test_random_stream();
        test_fill_stalled(waiting);
        test_drain(waiting);
        $display("errors: data %0d, level %0d, flag %0d, other %0d",
                 data_errors, level_errors, flag_errors, other_errors);
        if (data_errors + level_errors + flag_errors + other_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("watchdog expired: the tests did not finish in the expected time");
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

// File: src.f
hw/buf_cfg_pkg.sv
hw/link_pkg.sv
hw/fifo_mem.sv
hw/fifo_fwft.sv
hw/link_rx.sv
hw/link_tx.sv
hw/stream_buffer.sv
testbench/tb_stream_buffer.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the stream buffer testbench with Verilator.
# Exit status is nonzero when the build fails or the log holds the fail message.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
    -f src.f \
    --top-module tb_stream_buffer \
    --Mdir obj_dir \
    -o sim_tb > build.log 2>&1 \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || { echo "build or simulation run failed, see build.log and sim.log"; exit 1; }

cat sim.log

grep -q "FAIL: see errors above" sim.log \
    && { echo "simulation reported failure"; exit 1; } \
    || { echo "simulation finished without failure"; exit 0; }
